//--- sorter.f
rtl/sorterPkg.sv
rtl/plbXferIf.sv
rtl/sortIf.sv
rtl/plbMaster.sv
rtl/sortCore.sv
rtl/sortControl.sv
rtl/sorter.sv
verif/sorter_assertions.sv
verif/sorterTb.sv

//--- run.sh
#!/bin/sh
# compile and run the sorter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sorterTb \
  -f sorter.f -o sorterSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sorterSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

//--- verif/sorterTb.sv
module sorterTb;

  localparam int MAX_KEYS = 8;
  // plb slave model depth in 64-bit words
  localparam int PLB_WORDS = 64;
  localparam int NUM_CASES = 8;
  // two beats per key at up to 12 cycles each plus the sort and mailbox overhead
  localparam int CYCLE_LIMIT = NUM_CASES * (MAX_KEYS * 2 * 12 + MAX_KEYS + 50) + 16;

  typedef struct packed {
    logic [6:0]  count;
    logic [23:0] baseLine;
    // beat that gets mErr counted from 1, or 0 for none
    logic [7:0]  errBeat;
    logic        expErr;
  } caseRow_t;

  // count, baseLine, errBeat, expErr
  caseRow_t caseTable [NUM_CASES] = '{
    '{7'd5, 24'd2, 8'd0, 1'b0},
    '{7'd1, 24'd12, 8'd0, 1'b0},
    '{7'(MAX_KEYS), 24'd20, 8'd0, 1'b0},
    '{7'd0, 24'd30, 8'd0, 1'b1},
    '{7'(MAX_KEYS + 4), 24'd34, 8'd0, 1'b1},
    // error lands on a read beat, so memory stays as it was
    '{7'd6, 24'd40, 8'd3, 1'b1},
    '{7'd7, 24'd46, 8'd0, 1'b0},
    '{7'(MAX_KEYS), 24'd54, 8'd0, 1'b0}
  };

  logic        CLK = 1'b0;
  logic        rst;
  logic [31:0] mABus;
  logic        mRNW;
  logic        mRequest;
  logic [63:0] mWrDBus;
  logic        mAddrAck = 1'b0;
  logic        mRdDAck = 1'b0;
  logic        mWrDAck = 1'b0;
  logic        mErr = 1'b0;
  logic [63:0] mRdDBus = '0;
  logic [31:0] bramAddr;
  logic [31:0] bramDout;
  logic [3:0]  bramWEN;
  logic        bramEN;
  logic        bramCLK;
  logic        bramRST;
  logic [31:0] bramDin = '0;

  logic [63:0] plbMem [PLB_WORDS];
  logic [31:0] bramMem [16];
  logic [63:0] refKeys [MAX_KEYS];
  logic [7:0]  errBeat = '0;
  int          beatNum = 0;
  int          seed = 32'h75e20b00;
  int          cycleCount = 0;
  int          mismatchCount = 0;
  int          otherCount = 0;

  sorter #(.MAX_KEYS(MAX_KEYS)) dut0 (
    .CLK(CLK), .rst(rst),
    .mABus(mABus), .mRNW(mRNW), .mRequest(mRequest), .mWrDBus(mWrDBus),
    .mAddrAck(mAddrAck), .mRdDAck(mRdDAck), .mWrDAck(mWrDAck), .mErr(mErr),
    .mRdDBus(mRdDBus),
    .bramAddr(bramAddr), .bramDout(bramDout), .bramWEN(bramWEN), .bramEN(bramEN),
    .bramCLK(bramCLK), .bramRST(bramRST), .bramDin(bramDin)
  );

  always #5 CLK = ~CLK;

  task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    mismatchCount++;
    $display("[ERROR] %0t %s expected %h actual %h", $time, name, expVal, actVal);
  endtask

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    // bram reset mirrors the sorter reset
    if (bramRST !== rst) begin
      reportMismatch("bramRST", rst, bramRST);
    end
  end

  // one plb beat entered at the drive point with mRequest high
  task automatic serveBeat();
    int          addrWait;
    int          dataWait;
    int          slot;
    bit          inject;
    logic        rnw;
    logic [31:0] addr;
    logic [63:0] wdata;
    addrWait = $random(seed) & 3;
    dataWait = $random(seed) & 3;
    beatNum++;
    inject = (beatNum == int'(errBeat));
    repeat (addrWait) begin
      @(posedge CLK);
      #1;
    end
    addr  = mABus;
    rnw   = mRNW;
    wdata = mWrDBus;
    if (addr[31:9] != '0 || addr[2:0] != '0) begin
      otherCount++;
      $display("PLB address %h is outside the slave memory or not 8-byte aligned", addr);
    end
    slot = int'(addr[8:3]);
    mAddrAck = 1'b1;
    // zero data wait acks data together with the address
    if (dataWait > 0) begin
      @(posedge CLK);
      #1;
      mAddrAck = 1'b0;
      repeat (dataWait - 1) begin
        @(posedge CLK);
        #1;
      end
    end
    if (inject) begin
      mErr = 1'b1;
    end else if (rnw) begin
      mRdDAck = 1'b1;
      mRdDBus = plbMem[slot];
    end else begin
      mWrDAck = 1'b1;
      plbMem[slot] = wdata;
    end
    @(posedge CLK);
    #1;
    mAddrAck = 1'b0;
    mRdDAck  = 1'b0;
    mWrDAck  = 1'b0;
    mErr     = 1'b0;
  endtask

  // plb slave with random ack latency
  always begin
    @(posedge CLK);
    #1;
    if (mRequest && !rst) begin
      serveBeat();
    end
  end

  // bram on its own clock with one cycle read latency and the request sampled mid-cycle
  always begin
    logic        en;
    logic [3:0]  wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    @(negedge bramCLK);
    en    = bramEN;
    wen   = bramWEN;
    addr  = bramAddr;
    wdata = bramDout;
    @(posedge bramCLK);
    #1;
    if (en) begin
      if (addr[31:6] != '0) begin
        otherCount++;
        $display("BRAM address %h is outside the mailbox model", addr);
      end
      for (int b = 0; b < 4; b++) begin
        if (wen[b]) begin
          bramMem[addr[5:2]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      bramDin = bramMem[addr[5:2]];
    end
  end

  // ascending unsigned insertion sort
  task automatic sortRefKeys(input int n);
    logic [63:0] key;
    int          j;
    for (int i = 1; i < n; i++) begin
      key = refKeys[i];
      j = i - 1;
      while (j >= 0 && refKeys[j] > key) begin
        refKeys[j + 1] = refKeys[j];
        j--;
      end
      refKeys[j + 1] = key;
    end
  endtask

  task automatic runCase(input int c);
    caseRow_t    row;
    logic [63:0] expMem [PLB_WORDS];
    logic [31:0] expStatus;
    int          n;
    int          base;
    row  = caseTable[c];
    n    = int'(row.count);
    base = int'(row.baseLine);
    for (int i = 0; i < PLB_WORDS; i++) begin
      plbMem[i] = {$random(seed), $random(seed)};
    end
    // top key repeats the second one
    if (n >= 3 && n <= MAX_KEYS) begin
      plbMem[base + n - 1] = plbMem[base + 1];
    end
    expMem  = plbMem;
    beatNum = 0;
    errBeat = row.errBeat;
    bramMem[0] = {1'b1, row.count, row.baseLine};
    // go clears once the status word is written back
    while (bramMem[0][31]) begin
      @(posedge CLK);
      #1;
    end
    expStatus = {1'b0, 1'b1, row.expErr, row.count, 22'd0};
    if (bramMem[0] !== expStatus) begin
      reportMismatch($sformatf("case %0d bramMem[0]", c), 64'(expStatus), 64'(bramMem[0]));
    end
    if (!row.expErr) begin
      for (int i = 0; i < n; i++) begin
        refKeys[i] = expMem[base + i];
      end
      sortRefKeys(n);
      for (int i = 0; i < n; i++) begin
        expMem[base + i] = refKeys[i];
      end
    end
    for (int i = 0; i < PLB_WORDS; i++) begin
      if (plbMem[i] !== expMem[i]) begin
        reportMismatch($sformatf("case %0d plbMem[%0d]", c, i), expMem[i], plbMem[i]);
      end
    end
  endtask

  task automatic endRun();
    $display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    for (int i = 0; i < 16; i++) begin
      bramMem[i] = '0;
    end
    rst = 1'b1;
    repeat (16) @(posedge CLK);
    #1;
    rst = 1'b0;
    for (int c = 0; c < NUM_CASES; c++) begin
      runCase(c);
    end
    endRun();
  end

  initial begin
    wait (cycleCount >= CYCLE_LIMIT);
    otherCount++;
    $display("timeout after %0d cycles, no status word appeared in the mailbox", cycleCount);
    endRun();
  end

endmodule

//--- verif/sorter_assertions.sv
module sorterAssertions (
  input logic        CLK,
  input logic        rst,
  input logic        mRequest,
  input logic        mAddrAck,
  input logic        mRNW,
  input logic [31:0] mABus,
  input logic        bramEN,
  input logic [3:0]  bramWEN
);

  // a waiting request keeps its address and direction
  reqStable: assert property (@(posedge CLK) disable iff (rst)
    mRequest && !mAddrAck |=> $stable(mABus) && $stable(mRNW))
    else $error("mABus or mRNW changed while mRequest waited for mAddrAck");

  // byte enables only with the bram enable
  wenNeedsEn: assert property (@(posedge CLK) disable iff (rst)
    bramWEN != 4'b0000 |-> bramEN)
    else $error("bramWEN set without bramEN");

  // no bus request out of reset
  reqLowInReset: assert property (@(posedge CLK)
    rst |=> !mRequest)
    else $error("mRequest high during reset");

endmodule

bind sorter sorterAssertions assertions0 (
  .CLK      (CLK),
  .rst      (rst),
  .mRequest (mRequest),
  .mAddrAck (mAddrAck),
  .mRNW     (mRNW),
  .mABus    (mABus),
  .bramEN   (bramEN),
  .bramWEN  (bramWEN)
);

//--- rtl/sorter.sv
module sorter import sorterPkg::*; #(
  parameter int MAX_KEYS = 8
) (
  input  logic                  CLK,
  input  logic                  rst,
  // plb master
  output logic [PLB_ADDR_W-1:0] mABus,
  output logic                  mRNW,
  output logic                  mRequest,
  output logic [KEY_W-1:0]      mWrDBus,
  input  logic                  mAddrAck,
  input  logic                  mRdDAck,
  input  logic                  mWrDAck,
  input  logic                  mErr,
  input  logic [KEY_W-1:0]      mRdDBus,
  // bram initiator
  output logic [31:0]           bramAddr,
  output logic [31:0]           bramDout,
  output logic [3:0]            bramWEN,
  output logic                  bramEN,
  output logic                  bramCLK,
  output logic                  bramRST,
  input  logic [31:0]           bramDin
);

  logic [BRAM_IDX_W-1:0] bramIdx;

  plbXferIf xferBus ();
  sortIf #(.MAX_KEYS(MAX_KEYS)) sortBus ();

  // mailbox sequencer
  sortControl #(.MAX_KEYS(MAX_KEYS)) control0 (
    .CLK      (CLK),
    .rst      (rst),
    .xfer     (xferBus.controller),
    .sort     (sortBus.controller),
    .bramIdx  (bramIdx),
    .bramDout (bramDout),
    .bramWEN  (bramWEN),
    .bramEN   (bramEN),
    .bramDin  (bramDin)
  );

  plbMaster master0 (
    .CLK      (CLK),
    .rst      (rst),
    .xfer     (xferBus.engine),
    .mABus    (mABus),
    .mRNW     (mRNW),
    .mRequest (mRequest),
    .mWrDBus  (mWrDBus),
    .mAddrAck (mAddrAck),
    .mRdDAck  (mRdDAck),
    .mRdDBus  (mRdDBus),
    .mWrDAck  (mWrDAck),
    .mErr     (mErr)
  );

  sortCore #(.MAX_KEYS(MAX_KEYS)) core0 (
    .CLK  (CLK),
    .rst  (rst),
    .sort (sortBus.core)
  );

  // byte address from the 14-bit word index
  assign bramAddr = {{(32 - BRAM_IDX_W - 2){1'b0}}, bramIdx, 2'b00};

  // bram runs on the sorter clock and reset
  assign bramCLK = CLK;
  assign bramRST = rst;

endmodule

//--- rtl/sortControl.sv
module sortControl import sorterPkg::*; #(
  parameter int MAX_KEYS = 8
) (
  input  logic                  CLK,
  input  logic                  rst,
  plbXferIf.controller          xfer,
  sortIf.controller             sort,
  output logic [BRAM_IDX_W-1:0] bramIdx,
  output logic [31:0]           bramDout,
  output logic [3:0]            bramWEN,
  output logic                  bramEN,
  input  logic [31:0]           bramDin
);

  localparam int IDX_W = $clog2(MAX_KEYS);

  typedef enum logic [2:0] {
    ctlIdle,
    ctlPoll,
    ctlDecode,
    ctlLoad,
    ctlSort,
    ctlStore,
    ctlReport
  } ctlState_t;

  ctlState_t              state;
  mailboxWord_u           rdWord;
  mailboxWord_u           wrWord;
  mailboxCmd_t            cmdR;
  logic                   errR;
  logic                   pending;
  logic                   sortStartR;
  logic [IDX_W-1:0]       keyIdx;
  logic                   lastKey;
  logic                   legalCount;
  logic [PLB_ADDR_W-4:0]  lineAddr;

  // mailbox read as a command
  assign rdWord     = bramDin;
  assign legalCount = (rdWord.cmd.count != '0) && (rdWord.cmd.count <= COUNT_W'(MAX_KEYS));
  assign lastKey    = (COUNT_W'(keyIdx) == cmdR.count - 1'b1);

  always_ff @(posedge CLK) begin
    if (rst) begin
      state      <= ctlIdle;
      errR       <= 1'b0;
      pending    <= 1'b0;
      sortStartR <= 1'b0;
      keyIdx     <= '0;
    end else begin
      sortStartR <= 1'b0;
      // one transfer in flight at a time
      if (xfer.start) begin
        pending <= 1'b1;
      end else if (xfer.done) begin
        pending <= 1'b0;
      end
      case (state)
        ctlIdle: state <= ctlPoll;
        ctlPoll: state <= ctlDecode;
        ctlDecode: begin
          if (!rdWord.cmd.go) begin
            state <= ctlPoll;
          end else begin
            cmdR   <= rdWord.cmd;
            keyIdx <= '0;
            errR   <= !legalCount;
            // bad count goes straight to status
            state  <= legalCount ? ctlLoad : ctlReport;
          end
        end
        ctlLoad: begin
          if (xfer.done) begin
            if (xfer.err) begin
              errR  <= 1'b1;
              state <= ctlReport;
            end else if (lastKey) begin
              sortStartR <= 1'b1;
              state      <= ctlSort;
            end else begin
              keyIdx <= keyIdx + 1'b1;
            end
          end
        end
        ctlSort: begin
          if (sort.sortDone) begin
            keyIdx <= '0;
            state  <= ctlStore;
          end
        end
        ctlStore: begin
          if (xfer.done) begin
            if (xfer.err) begin
              errR  <= 1'b1;
              state <= ctlReport;
            end else if (lastKey) begin
              state <= ctlReport;
            end else begin
              keyIdx <= keyIdx + 1'b1;
            end
          end
        end
        // status write takes one cycle, polling resumes after it
        ctlReport: state <= ctlPoll;
        default: state <= ctlIdle;
      endcase
    end
  end

  // key address, base line plus one line per key
  assign lineAddr = (PLB_ADDR_W - 3)'(cmdR.baseLine) + (PLB_ADDR_W - 3)'(keyIdx);

  assign xfer.start  = (state == ctlLoad || state == ctlStore) && !pending;
  assign xfer.write  = (state == ctlStore);
  assign xfer.addr   = {lineAddr, 3'b000};
  assign xfer.wrData = sort.keyOut;

  // read data goes straight into the addressed slot
  assign sort.load      = (state == ctlLoad) && xfer.done && !xfer.err;
  assign sort.idx       = keyIdx;
  assign sort.keyIn     = xfer.rdData;
  assign sort.sortStart = sortStartR;

  // status word, go cleared so the next poll sees an idle mailbox
  assign wrWord.status = '{go: 1'b0, done: 1'b1, err: errR, count: cmdR.count, zero: '0};

  // mailbox lives at word 0
  assign bramIdx  = '0;
  assign bramEN   = (state == ctlPoll) || (state == ctlReport);
  assign bramWEN  = {4{state == ctlReport}};
  assign bramDout = wrWord;

endmodule

//--- rtl/sortCore.sv
module sortCore import sorterPkg::*; #(
  parameter int MAX_KEYS = 8
) (
  input logic CLK,
  input logic rst,
  sortIf.core sort
);

  localparam int IDX_W = $clog2(MAX_KEYS);

  logic [KEY_W-1:0] keys [MAX_KEYS];
  logic [KEY_W-1:0] nextKeys [MAX_KEYS];
  // highest slot written plus one
  logic [IDX_W:0]   loadedCnt;
  logic [IDX_W-1:0] phase;
  logic             sorting;
  logic             lastPhase;

  assign lastPhase = (phase == IDX_W'(MAX_KEYS - 1));

  // one compare-exchange phase
  // even phase pairs (0,1),(2,3)..., odd phase pairs (1,2),(3,4)...
  always_comb begin
    nextKeys = keys;
    for (int i = 0; i + 1 < MAX_KEYS; i++) begin
      if ((i % 2) == int'(phase[0]) && keys[i] > keys[i+1]) begin
        nextKeys[i]   = keys[i+1];
        nextKeys[i+1] = keys[i];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      sorting   <= 1'b0;
      phase     <= '0;
      loadedCnt <= '0;
    end else begin
      if (!sorting && sort.sortStart) begin
        sorting <= 1'b1;
        phase   <= '0;
      end else if (sorting) begin
        phase <= phase + 1'b1;
        if (lastPhase) begin
          sorting   <= 1'b0;
          // next block starts empty
          loadedCnt <= '0;
        end
      end
      // slot 0 opens a new block, so a stale count from an aborted load drops
      if (!sorting && sort.load) begin
        if (sort.idx == '0 || {1'b0, sort.idx} >= loadedCnt) begin
          loadedCnt <= {1'b0, sort.idx} + 1'b1;
        end
      end
    end
  end

  // key storage
  always_ff @(posedge CLK) begin
    if (sorting) begin
      keys <= nextKeys;
    end else if (sort.sortStart) begin
      // unused slots get all ones and sink to the top
      for (int i = 0; i < MAX_KEYS; i++) begin
        if (i >= int'(loadedCnt)) begin
          keys[i] <= '1;
        end
      end
    end else if (sort.load) begin
      keys[sort.idx] <= sort.keyIn;
    end
  end

  // pulses during the last phase, MAX_KEYS cycles after start
  assign sort.sortDone = sorting && lastPhase;
  assign sort.keyOut   = keys[sort.idx];

endmodule

//--- rtl/plbMaster.sv
module plbMaster import sorterPkg::*; (
  input  logic                  CLK,
  input  logic                  rst,
  plbXferIf.engine              xfer,
  output logic [PLB_ADDR_W-1:0] mABus,
  output logic                  mRNW,
  output logic                  mRequest,
  output logic [KEY_W-1:0]      mWrDBus,
  input  logic                  mAddrAck,
  input  logic                  mRdDAck,
  input  logic [KEY_W-1:0]      mRdDBus,
  input  logic                  mWrDAck,
  input  logic                  mErr
);

  typedef enum logic [1:0] {
    engIdle,
    engAddr,
    engData
  } engState_t;

  engState_t             state;
  logic [PLB_ADDR_W-1:0] addrR;
  logic                  writeR;
  logic [KEY_W-1:0]      wrDataR;
  logic [KEY_W-1:0]      rdDataR;
  logic                  doneR;
  logic                  errR;
  logic                  dataAck;
  logic                  finish;

  // data ack that belongs to the current direction
  assign dataAck = writeR ? mWrDAck : mRdDAck;

  // end of transfer, data ack or a bus error in either wait phase
  always_comb begin
    case (state)
      // slave may ack data together with the address
      engAddr: finish = mErr || (mAddrAck && dataAck);
      engData: finish = mErr || dataAck;
      default: finish = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= engIdle;
      doneR <= 1'b0;
      errR  <= 1'b0;
    end else begin
      // done trails the ack by one cycle
      doneR <= finish;
      errR  <= finish && mErr;
      case (state)
        engIdle: begin
          if (xfer.start) begin
            state <= engAddr;
          end
        end
        engAddr: begin
          if (finish) begin
            state <= engIdle;
          end else if (mAddrAck) begin
            state <= engData;
          end
        end
        engData: begin
          if (finish) begin
            state <= engIdle;
          end
        end
        default: state <= engIdle;
      endcase
    end
  end

  // transfer payload, held for the whole request
  always_ff @(posedge CLK) begin
    if (state == engIdle && xfer.start) begin
      addrR   <= xfer.addr;
      writeR  <= xfer.write;
      wrDataR <= xfer.wrData;
    end
    if (finish && !writeR) begin
      rdDataR <= mRdDBus;
    end
  end

  // request held until address ack
  assign mRequest = (state == engAddr);
  assign mABus    = addrR;
  assign mRNW     = ~writeR;
  assign mWrDBus  = wrDataR;

  assign xfer.rdData = rdDataR;
  assign xfer.done   = doneR;
  assign xfer.err    = errR;

endmodule

//--- rtl/sortIf.sv
interface sortIf import sorterPkg::*; #(
  parameter int MAX_KEYS = 8
) ();

  // slot index width
  localparam int IDX_W = $clog2(MAX_KEYS);

  logic             load;
  logic [IDX_W-1:0] idx;
  logic [KEY_W-1:0] keyIn;
  logic             sortStart;
  logic             sortDone;
  // slot idx, combinational
  logic [KEY_W-1:0] keyOut;

  modport controller (
    output load, idx, keyIn, sortStart,
    input  sortDone, keyOut
  );

  modport core (
    input  load, idx, keyIn, sortStart,
    output sortDone, keyOut
  );

endinterface

//--- rtl/plbXferIf.sv
interface plbXferIf import sorterPkg::*; ();

  // request side, from the sequencer
  logic                  start;
  logic                  write;
  logic [PLB_ADDR_W-1:0] addr;
  logic [KEY_W-1:0]      wrData;

  // completion side, from the bus engine
  logic [KEY_W-1:0]      rdData;
  logic                  done;
  logic                  err;

  modport controller (
    output start, write, addr, wrData,
    input  rdData, done, err
  );

  // single-beat engine
  modport engine (
    input  start, write, addr, wrData,
    output rdData, done, err
  );

endinterface

//--- rtl/sorterPkg.sv
package sorterPkg;

  // key width matches the 64-bit plb data bus
  localparam int KEY_W = 64;
  // plb byte address
  localparam int PLB_ADDR_W = 32;
  // bram word index, shifted up by two for the byte address
  localparam int BRAM_IDX_W = 14;

  // mailbox field widths
  localparam int COUNT_W = 7;
  localparam int LINE_W = 24;

  // command as written by the host
  typedef struct packed {
    logic               go;
    logic [COUNT_W-1:0] count;
    // base address in 8-byte lines
    logic [LINE_W-1:0]  baseLine;
  } mailboxCmd_t;

  // status as written back by the sorter
  typedef struct packed {
    logic               go;
    logic               done;
    logic               err;
    logic [COUNT_W-1:0] count;
    logic [21:0]        zero;
  } mailboxStatus_t;

  // one bram word, command on read and status on write-back
  typedef union packed {
    mailboxCmd_t    cmd;
    mailboxStatus_t status;
  } mailboxWord_u;

endpackage
